//--- pyonpyon_pkg.sv
package pyonpyon_pkg;

  // ----------------------------------------------------------------------
  // widths with a meaning
  // ----------------------------------------------------------------------
  typedef logic [3:0]  bcd_digit_t;   // one decimal digit
  typedef logic [7:0]  bcd_pair_t;    // tens in [7:4], units in [3:0]
  typedef logic [6:0]  seg_t;         // active low, segment g in bit 6
  typedef logic [32:0] course_t;      // 0 = left, 1 = right, bit 0 is the head
  typedef logic [27:0] divisor_t;     // divider reload value
  typedef logic [1:0]  speed_t;       // 0 easy, 1 medium, 2 hard, 3 extreme

  typedef enum logic [1:0] {
    race_ready,                       // waiting for enable
    race_running,                     // clocks and keys live
    race_player_won,                  // player reached the last box
    race_cpu_won                      // cpu count ran out
  } race_state_e;

  localparam course_t COURSE = 33'b0_1101_0001_0101_1101_1001_0110_1000_1001;
  localparam bcd_pair_t COURSE_BOXES = 8'h32;   // 32 in bcd
  localparam int VIEW_BOXES = 8;                // boxes shown ahead of the player

  // 50 MHz board values
  localparam divisor_t SECOND_DIVISOR_DEFAULT = 28'd49_999_999;   // 1 Hz
  localparam divisor_t CPU_DIVISORS_DEFAULT [4] = '{
    28'd33_333_332,                   // easy, 1.5 Hz
    28'd24_999_999,                   // medium, 2 Hz
    28'd16_666_665,                   // hard, 3 Hz
    28'd9_999_999                     // extreme, 5 Hz
  };

  function automatic seg_t seg_code(input bcd_digit_t digit);
    case (digit)
      4'h0: seg_code = 7'b100_0000;
      4'h1: seg_code = 7'b111_1001;
      4'h2: seg_code = 7'b010_0100;
      4'h3: seg_code = 7'b011_0000;
      4'h4: seg_code = 7'b001_1001;
      4'h5: seg_code = 7'b001_0010;
      4'h6: seg_code = 7'b000_0010;
      4'h7: seg_code = 7'b111_1000;
      4'h8: seg_code = 7'b000_0000;
      4'h9: seg_code = 7'b001_0000;
      default: seg_code = 7'b100_0000;   // non-decimal codes read as 0
    endcase
  endfunction

endpackage

//--- score_if.sv
`timescale 1ns/1ps

interface score_if
  import pyonpyon_pkg::*;
();

  bcd_pair_t timer;    // seconds since start
  bcd_pair_t best;     // record time
  bcd_pair_t cpu;      // boxes left for the cpu
  bcd_pair_t player;   // boxes the player has taken

  modport source (
    output timer, best, cpu, player
  );

  modport sink (
    input timer, best, cpu, player
  );

endinterface

//--- bcd_counter.sv
`timescale 1ns/1ps

module bcd_counter
  import pyonpyon_pkg::*;
#(
  parameter bit count_down = 1'b0     // 1 counts down, 0 counts up
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      load,
  input  bcd_pair_t load_value,
  input  logic      count_enable,
  output bcd_pair_t value
);

  bcd_digit_t tens;
  bcd_digit_t units;
  bcd_pair_t  next_value;   // value after one count

  assign tens  = value[7:4];
  assign units = value[3:0];

  always_comb begin
    next_value = value;
    if (count_down) begin
      if (units == 4'd0) begin
        next_value[3:0] = 4'd9;                                   // borrow
        next_value[7:4] = (tens == 4'd0) ? 4'd9 : tens - 4'd1;    // 00 wraps to 99
      end else begin
        next_value[3:0] = units - 4'd1;
      end
    end else begin
      if (units == 4'd9) begin
        next_value[3:0] = 4'd0;                                   // carry
        next_value[7:4] = (tens == 4'd9) ? 4'd0 : tens + 4'd1;    // 99 wraps to 00
      end else begin
        next_value[3:0] = units + 4'd1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      value <= load_value;
    end else if (load) begin
      value <= load_value;      // load wins over a count in the same cycle
    end else if (count_enable) begin
      value <= next_value;
    end
  end

endmodule

//--- box_track.sv
`timescale 1ns/1ps

module box_track
  import pyonpyon_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  restart,
  input  logic                  running,
  input  logic                  left_key,
  input  logic                  right_key,
  output logic                  step,         // one cycle per correct key edge
  output logic [VIEW_BOXES-1:0] next_boxes    // head box in bit 0
);

  course_t course_q;      // remaining course
  logic    head;          // side of the next box
  logic    match;         // a held key agrees with the head box
  logic    match_d;       // match one cycle back
  logic    step_q;        // registered edge of match

  assign head  = course_q[0];
  assign match = running && ((left_key && !head) || (right_key && head));

  // ----------------------------------------------------------------------
  // key edge to step
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      match_d <= 1'b0;
      step_q  <= 1'b0;
    end else if (restart) begin
      match_d <= 1'b0;
      step_q  <= 1'b0;
    end else begin
      match_d <= match;
      step_q  <= match && !match_d;   // rising edge only, a held key steps once
    end
  end

  assign step = step_q && running;     // nothing lands after a pause or a finish

  // ----------------------------------------------------------------------
  // course shifter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      course_q <= COURSE;
    end else if (restart) begin
      course_q <= COURSE;
    end else if (step) begin
      course_q <= {1'b0, course_q[32:1]};   // next box moves to the head
    end
  end

  assign next_boxes = course_q[VIEW_BOXES-1:0];

endmodule

//--- pace_timer.sv
`timescale 1ns/1ps

module pace_timer
  import pyonpyon_pkg::*;
#(
  parameter divisor_t second_divisor = SECOND_DIVISOR_DEFAULT,
  parameter divisor_t cpu_divisors [4] = CPU_DIVISORS_DEFAULT
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   restart,
  input  logic   running,
  input  speed_t speed,
  output logic   second_tick,   // one cycle every second_divisor+1 cycles
  output logic   cpu_tick       // one cycle every selected divisor+1 cycles
);

  divisor_t second_count;   // 1 Hz down-counter
  divisor_t cpu_count;      // cpu pace down-counter
  divisor_t cpu_reload;     // reload for the chosen speed

  assign cpu_reload = cpu_divisors[speed];

  assign second_tick = running && (second_count == '0);
  assign cpu_tick    = running && (cpu_count == '0);

  // ----------------------------------------------------------------------
  // seconds divider
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      second_count <= second_divisor;
    end else if (restart) begin
      second_count <= second_divisor;
    end else if (running) begin
      if (second_count == '0) begin
        second_count <= second_divisor;       // tick cycle, start over
      end else begin
        second_count <= second_count - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // cpu divider
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cpu_count <= cpu_divisors[0];
    end else if (restart) begin
      cpu_count <= cpu_reload;                // picks up the current speed
    end else if (running) begin
      if (cpu_count == '0) begin
        cpu_count <= cpu_reload;              // a speed change applies from here
      end else begin
        cpu_count <= cpu_count - 1'b1;
      end
    end
  end

endmodule

//--- race_control.sv
`timescale 1ns/1ps

module race_control
  import pyonpyon_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     restart,
  input  logic     enable,
  input  logic     step,
  input  logic     second_tick,
  input  logic     cpu_tick,
  output logic     running,
  output logic     player_won,
  output logic     cpu_won,
  score_if.source  scores
);

  localparam bcd_pair_t last_step = COURSE_BOXES - 8'd1;   // 31, one box to go

  race_state_e state;
  bcd_pair_t   timer_value;
  bcd_pair_t   player_value;
  bcd_pair_t   cpu_value;
  bcd_pair_t   best_q;          // lowest winning time, 00 means none yet
  logic        player_done;     // this edge takes the player to 32
  logic        cpu_done;        // this edge takes the cpu to 00
  logic        timer_tick;

  assign player_done = step && (player_value == last_step);
  assign cpu_done    = cpu_tick && (cpu_value == 8'h01);
  assign timer_tick  = second_tick && !player_done && !cpu_done;   // clock stops at the finish

  assign running    = (state == race_running) && enable;   // enable low pauses the race
  assign player_won = (state == race_player_won);
  assign cpu_won    = (state == race_cpu_won);

  // ----------------------------------------------------------------------
  // race FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= race_ready;
    end else if (restart) begin
      state <= race_ready;
    end else begin
      case (state)
        race_ready:   if (enable) state <= race_running;
        race_running: begin
          if (player_done) begin
            state <= race_player_won;     // player wins a tie
          end else if (cpu_done) begin
            state <= race_cpu_won;
          end
        end
        default:      state <= state;     // won states hold until restart
      endcase
    end
  end

  // best time, kept across restarts
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      best_q <= '0;
    end else if (!restart && player_done) begin
      if (best_q == '0 || timer_value < best_q) begin   // packed bcd orders like binary
        best_q <= timer_value;
      end
    end
  end

  bcd_counter #(.count_down(1'b0)) timer_count (
    .clk          (clk),
    .reset        (reset),
    .load         (restart),
    .load_value   (8'h00),
    .count_enable (timer_tick),
    .value        (timer_value)
  );

  bcd_counter #(.count_down(1'b0)) player_count (
    .clk          (clk),
    .reset        (reset),
    .load         (restart),
    .load_value   (8'h00),
    .count_enable (step),
    .value        (player_value)
  );

  bcd_counter #(.count_down(1'b1)) cpu_count (
    .clk          (clk),
    .reset        (reset),
    .load         (restart),
    .load_value   (COURSE_BOXES),
    .count_enable (cpu_tick),
    .value        (cpu_value)
  );

  assign scores.timer  = timer_value;
  assign scores.best   = best_q;
  assign scores.cpu    = cpu_value;
  assign scores.player = player_value;

endmodule

//--- seg_display.sv
`timescale 1ns/1ps

module seg_display
  import pyonpyon_pkg::*;
(
  score_if.sink scores,
  output seg_t  hex_timer_lo,
  output seg_t  hex_timer_hi,
  output seg_t  hex_best_lo,
  output seg_t  hex_best_hi,
  output seg_t  hex_cpu_lo,
  output seg_t  hex_cpu_hi,
  output seg_t  hex_player_lo,
  output seg_t  hex_player_hi
);

  // units digit in the low nibble of each pair
  assign hex_timer_lo  = seg_code(scores.timer[3:0]);
  assign hex_timer_hi  = seg_code(scores.timer[7:4]);
  assign hex_best_lo   = seg_code(scores.best[3:0]);
  assign hex_best_hi   = seg_code(scores.best[7:4]);
  assign hex_cpu_lo    = seg_code(scores.cpu[3:0]);
  assign hex_cpu_hi    = seg_code(scores.cpu[7:4]);
  assign hex_player_lo = seg_code(scores.player[3:0]);
  assign hex_player_hi = seg_code(scores.player[7:4]);

endmodule

//--- pyonpyon_top.sv
`timescale 1ns/1ps

module pyonpyon_top
  import pyonpyon_pkg::*;
#(
  parameter divisor_t second_divisor = SECOND_DIVISOR_DEFAULT,
  parameter divisor_t cpu_divisors [4] = CPU_DIVISORS_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  restart,       // new race, best time kept
  input  logic                  enable,        // start and pause
  input  speed_t                speed,
  input  logic                  left_key,
  input  logic                  right_key,
  output logic [VIEW_BOXES-1:0] next_boxes,
  output logic                  player_won,
  output logic                  cpu_won,
  output seg_t                  hex_timer_lo,
  output seg_t                  hex_timer_hi,
  output seg_t                  hex_best_lo,
  output seg_t                  hex_best_hi,
  output seg_t                  hex_cpu_lo,
  output seg_t                  hex_cpu_hi,
  output seg_t                  hex_player_lo,
  output seg_t                  hex_player_hi
);

  logic step;          // correct key edge
  logic second_tick;   // timer advance
  logic cpu_tick;      // cpu advance
  logic running;       // race live and not paused

  score_if scores ();

  box_track box_track_i (
    .clk        (clk),
    .reset      (reset),
    .restart    (restart),
    .running    (running),
    .left_key   (left_key),
    .right_key  (right_key),
    .step       (step),
    .next_boxes (next_boxes)
  );

  pace_timer #(
    .second_divisor (second_divisor),
    .cpu_divisors   (cpu_divisors)
  ) pace_timer_i (
    .clk         (clk),
    .reset       (reset),
    .restart     (restart),
    .running     (running),
    .speed       (speed),
    .second_tick (second_tick),
    .cpu_tick    (cpu_tick)
  );

  race_control race_control_i (
    .clk         (clk),
    .reset       (reset),
    .restart     (restart),
    .enable      (enable),
    .step        (step),
    .second_tick (second_tick),
    .cpu_tick    (cpu_tick),
    .running     (running),
    .player_won  (player_won),
    .cpu_won     (cpu_won),
    .scores      (scores.source)
  );

  seg_display seg_display_i (
    .scores        (scores.sink),
    .hex_timer_lo  (hex_timer_lo),
    .hex_timer_hi  (hex_timer_hi),
    .hex_best_lo   (hex_best_lo),
    .hex_best_hi   (hex_best_hi),
    .hex_cpu_lo    (hex_cpu_lo),
    .hex_cpu_hi    (hex_cpu_hi),
    .hex_player_lo (hex_player_lo),
    .hex_player_hi (hex_player_hi)
  );

endmodule

//--- pyonpyon_assertions.sv
`timescale 1ns/1ps

module pyonpyon_assertions
  import pyonpyon_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      restart,
  input logic      player_won,
  input logic      cpu_won,
  input bcd_pair_t timer,
  input bcd_pair_t best,
  input bcd_pair_t cpu,
  input bcd_pair_t player
);

  function automatic logic pair_ok(input bcd_pair_t p);
    pair_ok = (p[7:4] <= 4'd9) && (p[3:0] <= 4'd9);
  endfunction

  // each won flag matches the count that ended the race
  a_player_end: assert property (@(posedge clk) disable iff (reset)
    player_won |-> (player == COURSE_BOXES)) else $error("player_won without 32 boxes");

  // the player takes a tie, so a cpu win leaves the player short
  a_cpu_end: assert property (@(posedge clk) disable iff (reset)
    cpu_won |-> (cpu == 8'h00 && player != COURSE_BOXES))
    else $error("cpu_won without a cpu finish");

  a_player_hold: assert property (@(posedge clk) disable iff (reset)
    (player_won && !restart) |=> player_won) else $error("player_won dropped");

  a_cpu_hold: assert property (@(posedge clk) disable iff (reset)
    (cpu_won && !restart) |=> cpu_won) else $error("cpu_won dropped");

  a_digits: assert property (@(posedge clk) disable iff (reset)
    pair_ok(timer) && pair_ok(best) && pair_ok(cpu) && pair_ok(player))
    else $error("displayed digit above 9");

endmodule

bind pyonpyon_top pyonpyon_assertions pyonpyon_assertions_i (
  .clk        (clk),
  .reset      (reset),
  .restart    (restart),
  .player_won (player_won),
  .cpu_won    (cpu_won),
  .timer      (race_control_i.timer_value),
  .best       (race_control_i.best_q),
  .cpu        (race_control_i.cpu_value),
  .player     (race_control_i.player_value)
);

//--- pyonpyon_tb.sv
`timescale 1ns/1ps

module pyonpyon_tb
  import pyonpyon_pkg::*;
();

  localparam divisor_t tb_second_divisor = 28'd19;                // 20 cycles per second
  localparam divisor_t tb_cpu_divisors [4] = '{28'd9, 28'd7, 28'd5, 28'd3};
  localparam int win_player = 1;
  localparam int win_cpu    = 2;

  typedef struct packed {
    speed_t     speed;
    logic [5:0] presses;    // correct presses to make
    logic       wrong;      // insert wrong presses at random
    logic [3:0] spacing;    // idle cycles after each press
    logic [1:0] winner;     // expected winner
  } race_row_t;

  // ----------------------------------------------------------------------
  // races: fast win, slow win, faster win, then the cpu at each speed
  // ----------------------------------------------------------------------
  localparam race_row_t races [7] = '{
    '{2'd0, 6'd32, 1'b1, 4'd1, 2'd1},
    '{2'd0, 6'd32, 1'b0, 4'd5, 2'd1},
    '{2'd0, 6'd32, 1'b0, 4'd0, 2'd1},
    '{2'd0, 6'd0,  1'b0, 4'd0, 2'd2},
    '{2'd1, 6'd0,  1'b0, 4'd0, 2'd2},
    '{2'd2, 6'd0,  1'b0, 4'd0, 2'd2},
    '{2'd3, 6'd0,  1'b0, 4'd0, 2'd2}
  };

  logic clk, reset, restart, enable, left_key, right_key;
  speed_t speed;
  logic [VIEW_BOXES-1:0] next_boxes;
  logic player_won, cpu_won;
  seg_t hex_now [8];
  string hex_names [8] = '{"timer_lo", "timer_hi", "best_lo", "best_hi",
                           "cpu_lo", "cpu_hi", "player_lo", "player_hi"};

  int value_errors = 0;
  int timeouts     = 0;
  int cyc          = 0;     // free-running cycle count
  int m_state      = 0;     // timer model: 0 ready, 1 running, 2 done
  int m_cycles     = 0;     // running cycles since restart
  int m_best       = 0;     // record time model
  logic [31:0] lfsr = 32'hc0d3;

  pyonpyon_top #(
    .second_divisor (tb_second_divisor),
    .cpu_divisors   (tb_cpu_divisors)
  ) pyonpyon_top_i (
    .clk (clk), .reset (reset), .restart (restart), .enable (enable), .speed (speed),
    .left_key (left_key), .right_key (right_key), .next_boxes (next_boxes),
    .player_won (player_won), .cpu_won (cpu_won),
    .hex_timer_lo (hex_now[0]), .hex_timer_hi (hex_now[1]),
    .hex_best_lo (hex_now[2]), .hex_best_hi (hex_now[3]),
    .hex_cpu_lo (hex_now[4]), .hex_cpu_hi (hex_now[5]),
    .hex_player_lo (hex_now[6]), .hex_player_hi (hex_now[7])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reference race model, sees inputs and flags as they were before the edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset || restart) begin
      m_state  = 0;
      m_cycles = 0;
    end else if (m_state == 0) begin
      if (enable) m_state = 1;
    end else if (m_state == 1) begin
      if (player_won || cpu_won) m_state = 2;   // race froze at the last edge
      else if (enable) m_cycles = m_cycles + 1;
    end
  end

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    galois_step = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = galois_step(lfsr);
  endtask

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_seg(input string name, input seg_t got, input seg_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_boxes(input logic [VIEW_BOXES-1:0] got, input logic [VIEW_BOXES-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED next_boxes got %h expected %h", got, exp);
      value_errors++;
    end
  endtask

  task automatic check_pair(input int idx, input int value);
    check_seg(hex_names[idx], hex_now[idx], seg_code(bcd_digit_t'(value % 10)));
    check_seg(hex_names[idx+1], hex_now[idx+1], seg_code(bcd_digit_t'(value / 10)));
  endtask

  function automatic logic [VIEW_BOXES-1:0] view_after(input int taken);
    course_t rest;
    rest = COURSE >> taken;
    view_after = rest[VIEW_BOXES-1:0];
  endfunction

  task automatic check_idle();
    @(negedge clk);
    check_pair(0, 0);
    check_pair(2, m_best);
    check_pair(4, 32);
    check_pair(6, 0);
    check_boxes(next_boxes, view_after(0));
    check_flag("player_won", player_won, 1'b0);
    check_flag("cpu_won", cpu_won, 1'b0);
  endtask

  // timer and cpu follow the model; both freeze at the finishing edge
  task automatic check_live(input int d);
    int t;
    int c;
    t = (player_won || cpu_won) ? (m_cycles - 1) / 20 : m_cycles / 20;
    c = 32 - m_cycles / (d + 1);
    if (c < 0) c = 0;
    check_pair(0, t);
    check_pair(4, c);
  endtask

  task automatic restart_race(input speed_t s);
    @(posedge clk);
    enable  <= 1'b0;
    speed   <= s;
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
  endtask

  task automatic press_key(input logic right, input int hold, input int gap);
    @(posedge clk);
    if (right) right_key <= 1'b1;
    else left_key <= 1'b1;
    repeat (hold) @(posedge clk);
    left_key  <= 1'b0;
    right_key <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  task automatic wait_finish(input int d);
    int k;
    k = 0;
    while (!(player_won || cpu_won) && k < 32 * (d + 1) + 200) begin
      @(negedge clk);
      check_live(d);
      k++;
    end
    if (!(player_won || cpu_won)) begin
      $display("timeout: no winner after %0d cycles", k);
      timeouts++;
    end
  endtask

  initial begin
    race_row_t row;
    logic b;
    int d;
    int start_cyc;
    seg_t snap [8];
    logic [VIEW_BOXES-1:0] snap_boxes;

    reset     = 1'b1;
    restart   = 1'b0;
    enable    = 1'b0;
    speed     = 2'd0;
    left_key  = 1'b0;
    right_key = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    check_idle();

    for (int i = 0; i < 7; i++) begin
      row = races[i];
      d   = int'(tb_cpu_divisors[row.speed]);
      restart_race(row.speed);
      check_idle();
      start_cyc = cyc;                        // cycle count before the enable edge
      @(posedge clk);
      enable <= 1'b1;
      for (int n = 0; n < int'(row.presses); n++) begin
        if (row.wrong) begin
          take_bit(b);
          if (b) begin
            press_key(!COURSE[n], 1, 0);      // opposite side, nothing moves
            @(negedge clk);
            check_boxes(next_boxes, view_after(n));
            check_pair(6, n);
          end
        end
        press_key(COURSE[n], 2, int'(row.spacing));
        @(negedge clk);
        check_boxes(next_boxes, view_after(n + 1));
        check_pair(6, n + 1);
      end
      wait_finish(d);
      check_flag("player_won", player_won, row.winner == win_player);
      check_flag("cpu_won", cpu_won, row.winner == win_cpu);
      if (row.winner == win_player) begin
        if (m_best == 0 || (m_cycles - 1) / 20 < m_best) m_best = (m_cycles - 1) / 20;
        check_pair(6, 32);
      end else begin
        check_pair(4, 0);
        check_pair(6, 0);
        if (cyc - start_cyc < 32 * (d + 1)) begin
          $display("cpu finished after %0d cycles, sooner than %0d", cyc - start_cyc,
                   32 * (d + 1));
          value_errors++;
        end
      end
      check_pair(2, m_best);
      repeat (25) @(negedge clk);
      check_live(d);                          // timer stays stopped
    end

    // held key, wrong key, then a pause in the middle of a race
    restart_race(2'd0);
    check_idle();
    @(posedge clk);
    enable <= 1'b1;
    press_key(COURSE[0], 2, 1);
    press_key(COURSE[1], 10, 1);              // next box is the same side
    press_key(!COURSE[2], 2, 1);
    @(negedge clk);
    check_boxes(next_boxes, view_after(2));
    check_pair(6, 2);
    @(posedge clk);
    enable <= 1'b0;
    @(negedge clk);
    snap       = hex_now;
    snap_boxes = next_boxes;
    press_key(COURSE[2], 2, 1);
    repeat (30) @(negedge clk);
    for (int j = 0; j < 8; j++) check_seg(hex_names[j], hex_now[j], snap[j]);
    check_boxes(next_boxes, snap_boxes);
    restart_race(2'd0);
    check_idle();

    $display("value errors %0d, timeouts %0d", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- pyonpyon.f
pyonpyon_pkg.sv
score_if.sv
bcd_counter.sv
box_track.sv
pace_timer.sv
race_control.sv
seg_display.sv
pyonpyon_top.sv
pyonpyon_assertions.sv
pyonpyon_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pyonpyon_tb
FILELIST  ?= pyonpyon.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
